//--- hdl/fetch_pkg.sv
package fetch_pkg;

    // ****************************************
    // widths
    // ****************************************

    localparam int unsigned xlen = 32;

    // ****************************************
    // instruction class
    // ****************************************

    // decides how the pc sequencer waits before it advances.
    typedef enum logic [2:0] {
        cls_alu,
        cls_mem,
        cls_muldiv,
        cls_ctrl,
        cls_jal
    } inst_class_e;

    // ****************************************
    // channel payloads
    // ****************************************

    // fetch request from the sequencer to the bus master.
    typedef struct packed {
        logic [xlen-1:0] addr;
    } fetch_req_t;

    // fetched word, fault is set on a non-OKAY rresp.
    typedef struct packed {
        logic [xlen-1:0] inst;
        logic            fault;
    } fetch_rsp_t;

    // what decode sees.
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        inst_class_e     cls;
        logic            fault;
    } fetch_out_t;

    // branch or jalr outcome from execute.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

    // pre-decoder result for the held instruction.
    typedef struct packed {
        inst_class_e     cls;
        logic [xlen-1:0] jal_target;
    } predecode_t;

endpackage

//--- hdl/pc_sequencer.sv
`timescale 1ns/1ns

module pc_sequencer #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rsp_valid,
    input  fetch_pkg::fetch_rsp_t rsp,
    input  fetch_pkg::predecode_t pdec,
    input  logic                  out_ready,
    input  logic                  mem_done,
    input  logic                  md_done,
    input  fetch_pkg::redirect_t  redirect,
    output logic                  req_valid,
    output fetch_pkg::fetch_req_t req,
    output fetch_pkg::fetch_out_t out,
    output logic                  out_valid
);

    localparam int unsigned xlen = fetch_pkg::xlen;
    localparam logic [xlen-1:0] pc_step = 4;

    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_resp,
        st_deliver,
        st_wait_mem,
        st_wait_md,
        st_wait_redir,
        st_halt
    } state_e;

    state_e          state;
    state_e          state_nxt;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_nxt;
    logic [xlen-1:0] hold_pc;
    logic [xlen-1:0] hold_inst;
    logic            hold_fault;
    logic            out_fire;

    assign out_fire = out_valid && out_ready;

    // ****************************************
    // next state and next pc
    // ****************************************

    always_comb begin
        state_nxt = state;
        pc_nxt    = pc;
        case (state)
            st_idle: begin
                state_nxt = st_req;
            end
            // master is idle here, so the request is always taken.
            st_req: begin
                state_nxt = st_resp;
            end
            st_resp: begin
                if (rsp_valid) begin
                    state_nxt = st_deliver;
                end
            end
            st_deliver: begin
                if (out_fire) begin
                    if (hold_fault) begin
                        state_nxt = st_halt;
                    end else begin
                        case (pdec.cls)
                            fetch_pkg::cls_mem:    state_nxt = st_wait_mem;
                            fetch_pkg::cls_muldiv: state_nxt = st_wait_md;
                            fetch_pkg::cls_ctrl:   state_nxt = st_wait_redir;
                            fetch_pkg::cls_jal: begin
                                pc_nxt    = pdec.jal_target;
                                state_nxt = st_req;
                            end
                            default: begin
                                pc_nxt    = pc + pc_step;
                                state_nxt = st_req;
                            end
                        endcase
                    end
                end
            end
            st_wait_mem: begin
                if (mem_done) begin
                    pc_nxt    = pc + pc_step;
                    state_nxt = st_req;
                end
            end
            st_wait_md: begin
                if (md_done) begin
                    pc_nxt    = pc + pc_step;
                    state_nxt = st_req;
                end
            end
            // a fault parks here until execute supplies a new pc.
            st_wait_redir, st_halt: begin
                if (redirect.valid) begin
                    pc_nxt    = redirect.target;
                    state_nxt = st_req;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // ****************************************
    // registers
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            pc    <= reset_pc;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
        end
    end

    // output register, loaded when the word arrives.
    always_ff @(posedge clk) begin
        if (state == st_resp && rsp_valid) begin
            hold_pc    <= pc;
            hold_inst  <= rsp.inst;
            hold_fault <= rsp.fault;
        end
    end

    assign req_valid = (state == st_req);
    assign req.addr  = pc;

    assign out_valid = (state == st_deliver);
    assign out.pc    = hold_pc;
    assign out.inst  = hold_inst;
    assign out.cls   = pdec.cls;
    assign out.fault = hold_fault;

endmodule

//--- hdl/axil_fetch_master.sv
`timescale 1ns/1ns

module axil_fetch_master (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  fetch_pkg::fetch_req_t       req,
    input  logic                        arready,
    input  logic                        rvalid,
    input  logic [fetch_pkg::xlen-1:0]  rdata,
    input  logic [1:0]                  rresp,
    output logic [fetch_pkg::xlen-1:0]  araddr,
    output logic [2:0]                  arprot,
    output logic                        arvalid,
    output logic                        rready,
    output logic                        rsp_valid,
    output fetch_pkg::fetch_rsp_t       rsp
);

    // instruction, privileged, secure.
    localparam logic [2:0] prot_fetch = 3'b101;
    localparam logic [1:0] resp_okay  = 2'b00;

    typedef enum logic [1:0] {
        m_idle,
        m_addr,
        m_data
    } mstate_e;

    mstate_e state;
    logic    ar_fire;
    logic    r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= m_idle;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                m_idle: begin
                    if (req_valid) begin
                        state <= m_addr;
                    end
                end
                m_addr: begin
                    if (ar_fire) begin
                        state <= m_data;
                    end
                end
                m_data: begin
                    if (r_fire) begin
                        state     <= m_idle;
                        rsp_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= m_idle;
                end
            endcase
        end
    end

    // address and returned word.
    always_ff @(posedge clk) begin
        if (state == m_idle && req_valid) begin
            araddr <= req.addr;
        end
        if (r_fire) begin
            rsp.inst  <= rdata;
            rsp.fault <= (rresp != resp_okay);
        end
    end

    assign arvalid = (state == m_addr);
    assign rready  = (state == m_data);
    assign arprot  = prot_fetch;

endmodule

//--- hdl/inst_predecode.sv
`timescale 1ns/1ns

module inst_predecode (
    input  logic [fetch_pkg::xlen-1:0] inst,
    input  logic [fetch_pkg::xlen-1:0] pc,
    output fetch_pkg::predecode_t      pdec
);

    localparam int unsigned xlen = fetch_pkg::xlen;

    // ****************************************
    // rv32 opcodes
    // ****************************************

    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // M extension lives in the register opcode.
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    logic [6:0]             opcode;
    logic [6:0]             funct7;
    logic [xlen-1:0]        j_imm;
    fetch_pkg::inst_class_e cls;

    assign opcode = inst[6:0];
    assign funct7 = inst[31:25];

    // j-type immediate, sign extended, bit 0 always zero.
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            op_load, op_store: begin
                cls = fetch_pkg::cls_mem;
            end
            op_reg: begin
                if (funct7 == funct7_muldiv) begin
                    cls = fetch_pkg::cls_muldiv;
                end else begin
                    cls = fetch_pkg::cls_alu;
                end
            end
            op_jalr, op_branch: begin
                cls = fetch_pkg::cls_ctrl;
            end
            op_jal: begin
                cls = fetch_pkg::cls_jal;
            end
            default: begin
                cls = fetch_pkg::cls_alu;
            end
        endcase
    end

    assign pdec.cls        = cls;
    assign pdec.jal_target = pc + j_imm;

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        arready,
    input  logic                        rvalid,
    input  logic [fetch_pkg::xlen-1:0]  rdata,
    input  logic [1:0]                  rresp,
    input  logic                        out_ready,
    input  logic                        mem_done,
    input  logic                        md_done,
    input  fetch_pkg::redirect_t        redirect,
    output logic [fetch_pkg::xlen-1:0]  araddr,
    output logic [2:0]                  arprot,
    output logic                        arvalid,
    output logic                        rready,
    output fetch_pkg::fetch_out_t       out,
    output logic                        out_valid
);

    logic                  req_valid;
    fetch_pkg::fetch_req_t req;
    logic                  rsp_valid;
    fetch_pkg::fetch_rsp_t rsp;
    fetch_pkg::predecode_t pdec;

    pc_sequencer #(
        .reset_pc (reset_pc)
    ) pc_sequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .pdec      (pdec),
        .out_ready (out_ready),
        .mem_done  (mem_done),
        .md_done   (md_done),
        .redirect  (redirect),
        .req_valid (req_valid),
        .req       (req),
        .out       (out),
        .out_valid (out_valid)
    );

    axil_fetch_master axil_fetch_master_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .araddr    (araddr),
        .arprot    (arprot),
        .arvalid   (arvalid),
        .rready    (rready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // classifies the word held in the output register.
    inst_predecode inst_predecode_i (
        .inst (out.inst),
        .pc   (out.pc),
        .pdec (pdec)
    );

endmodule

//--- test/imem_axil_model.sv
`timescale 1ns/1ns

module imem_axil_model (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fetch_pkg::xlen-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic                       rready,
    output logic                       rvalid,
    output logic [fetch_pkg::xlen-1:0] rdata,
    output logic [1:0]                 rresp,
    input  logic [3:0]                 ar_delay,
    input  logic [fetch_pkg::xlen-1:0] fault_addr
);

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // word array, index taken from the low address bits.
    logic [fetch_pkg::xlen-1:0] mem [0:255];
    logic [3:0]                 wait_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= resp_okay;
            wait_cnt <= '0;
        end else begin
            arready <= 1'b0;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid   <= 1'b1;
                rdata    <= mem[araddr[9:2]];
                rresp    <= (araddr == fault_addr) ? resp_slverr : resp_okay;
                wait_cnt <= '0;
            end else if (arvalid && !rvalid) begin
                // arready comes after ar_delay cycles of arvalid.
                if (wait_cnt >= ar_delay) begin
                    arready <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- test/fetch_unit_tb.sv
`timescale 1ns/1ns

module fetch_unit_tb;

    localparam logic [31:0] reset_pc   = 32'h8000_0000;
    localparam int unsigned max_cycles = 3000;

    // instruction, privileged, secure.
    localparam logic [2:0]  prot_fetch = 3'b101;

    // rv32 words used by the tests.
    localparam logic [31:0] lw_word   = {12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011};
    localparam logic [31:0] mul_word  = {7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011};
    localparam logic [31:0] jalr_word = {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};
    localparam logic [31:0] beq_word  = {7'd0, 5'd2, 5'd1, 3'b000, 5'd0, 7'b1100011};

    logic                       clk;
    logic                       rst_n;
    logic                       arready;
    logic                       rvalid;
    logic [fetch_pkg::xlen-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       out_ready;
    logic                       mem_done;
    logic                       md_done;
    fetch_pkg::redirect_t       redirect;
    logic [fetch_pkg::xlen-1:0] araddr;
    logic [2:0]                 arprot;
    logic                       arvalid;
    logic                       rready;
    fetch_pkg::fetch_out_t      out;
    logic                       out_valid;
    logic [3:0]                 ar_delay;
    logic [fetch_pkg::xlen-1:0] fault_addr;

    integer                     seed;
    int unsigned                cyc;
    int unsigned                rst_cyc;
    int unsigned                pulse_cyc;
    int unsigned                checks;
    int unsigned                errors;
    string                      cur_test;
    logic                       arvalid_q;
    logic                       stalled_q;
    logic                       r_wait;
    fetch_pkg::fetch_out_t      held_out;
    fetch_pkg::fetch_out_t      got_q[$];
    int unsigned                out_cyc_q[$];
    logic [fetch_pkg::xlen-1:0] addr_q[$];
    int unsigned                rise_q[$];

    fetch_unit #(
        .reset_pc (reset_pc)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .out_ready (out_ready),
        .mem_done  (mem_done),
        .md_done   (md_done),
        .redirect  (redirect),
        .araddr    (araddr),
        .arprot    (arprot),
        .arvalid   (arvalid),
        .rready    (rready),
        .out       (out),
        .out_valid (out_valid)
    );

    imem_axil_model imem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rready     (rready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .ar_delay   (ar_delay),
        .fault_addr (fault_addr)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ****************************************
    // word builders and compare tasks
    // ****************************************

    // addi x1, x0, k.
    function automatic logic [31:0] alu_word(input int unsigned k);
        return {k[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic fetch_pkg::fetch_out_t make_out(input logic [31:0] pc,
            input logic [31:0] inst, input fetch_pkg::inst_class_e cls, input logic fault);
        fetch_pkg::fetch_out_t o;
        o.pc    = pc;
        o.inst  = inst;
        o.cls   = cls;
        o.fault = fault;
        return o;
    endfunction

    function automatic int unsigned first_rise_after(input int unsigned c);
        foreach (rise_q[i]) begin
            if (rise_q[i] > c) begin
                return rise_q[i];
            end
        end
        return 0;
    endfunction

    task automatic check_out(input string name, input fetch_pkg::fetch_out_t exp,
            input fetch_pkg::fetch_out_t act);
        string exp_s;
        string act_s;
        checks++;
        if (act !== exp) begin
            errors++;
            exp_s = $sformatf("pc=%h inst=%h cls=%0d fault=%b",
                              exp.pc, exp.inst, exp.cls, exp.fault);
            act_s = $sformatf("pc=%h inst=%h cls=%0d fault=%b",
                              act.pc, act.inst, act.cls, act.fault);
            $display("CHECK FAILED %s: expected %s, actual %s", name, exp_s, act_s);
        end
    endtask

    task automatic check_addr(input string name, input logic [fetch_pkg::xlen-1:0] exp,
            input logic [fetch_pkg::xlen-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected araddr %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_prot(input string name, input logic [2:0] exp,
            input logic [2:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected arprot %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_cycles(input string name, input int unsigned exp,
            input int unsigned act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("CHECK FAILED %s: expected arvalid at cycle %0d, actual %0d",
                     name, exp, act);
        end
    endtask

    // ****************************************
    // monitor and stimulus helpers
    // ****************************************

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (out_valid && out_ready) begin
            got_q.push_back(out);
            out_cyc_q.push_back(cyc);
        end
        if (arvalid && arready) begin
            addr_q.push_back(araddr);
            check_prot({cur_test, " arprot"}, prot_fetch, arprot);
        end
        if (arvalid && !arvalid_q) begin
            rise_q.push_back(cyc);
        end
        if (mem_done || md_done || redirect.valid) begin
            pulse_cyc = cyc;
        end
        // rready spans the wait between the AR and R transfers.
        if (!rst_n) begin
            r_wait = 1'b0;
        end else begin
            check_flag({cur_test, " rready"}, r_wait, rready);
            if (arvalid && arready) begin
                r_wait = 1'b1;
            end else if (rvalid && rready) begin
                r_wait = 1'b0;
            end
        end
        // decode held off, the offered word must not move.
        if (stalled_q && out_valid) begin
            check_out({cur_test, " hold"}, held_out, out);
        end
        stalled_q = out_valid && !out_ready;
        held_out  = out;
        arvalid_q = arvalid;
        if (cyc >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic reset_dut(input string name, input logic [3:0] delay);
        int unsigned i;
        cur_test   = name;
        rst_n      = 1'b0;
        out_ready  = 1'b1;
        mem_done   = 1'b0;
        md_done    = 1'b0;
        redirect   = '0;
        ar_delay   = delay;
        fault_addr = '1;
        for (i = 0; i < 256; i++) begin
            imem_i.mem[i] = alu_word(i);
        end
        repeat (2) step();
        got_q.delete();
        out_cyc_q.delete();
        addr_q.delete();
        rise_q.delete();
        stalled_q = 1'b0;
        arvalid_q = 1'b0;
        rst_n     = 1'b1;
        rst_cyc   = cyc;
    endtask

    task automatic wait_out(input int unsigned n);
        while (got_q.size() < n) begin
            step();
        end
    endtask

    task automatic idle_cycles();
        int n;
        n = ($random(seed) & 7) + 3;
        repeat (n) step();
    endtask

    task automatic pulse_done(input logic mem, input logic md);
        mem_done = mem;
        md_done  = md;
        step();
        mem_done = 1'b0;
        md_done  = 1'b0;
    endtask

    task automatic give_redirect(input logic [31:0] target);
        redirect.valid  = 1'b1;
        redirect.target = target;
        step();
        redirect = '0;
    endtask

    task automatic load_alu_block();
        int unsigned k;
        for (k = 0; k < 8; k++) begin
            imem_i.mem[k] = alu_word(200 + k);
        end
    endtask

    task automatic check_alu_block(input string name);
        int unsigned k;
        for (k = 0; k < 8; k++) begin
            check_out(name, make_out(reset_pc + 4 * k, alu_word(200 + k),
                      fetch_pkg::cls_alu, 1'b0), got_q[k]);
            check_addr(name, reset_pc + 4 * k, addr_q[k]);
        end
    endtask

    // ****************************************
    // directed tests
    // ****************************************

    task automatic test_sequential();
        int unsigned k;
        reset_dut("sequential", $random(seed) & 3);
        load_alu_block();
        wait_out(8);
        check_alu_block("sequential");
        check_cycles("sequential first fetch", rst_cyc + 3, rise_q[0]);
        for (k = 0; k < 7; k++) begin
            check_cycles("sequential", out_cyc_q[k] + 2, first_rise_after(out_cyc_q[k]));
        end
    endtask

    task automatic test_jal();
        reset_dut("jal", $random(seed) & 3);
        imem_i.mem[1]  = jal_word(21'h00040);
        imem_i.mem[17] = jal_word(21'h1fffe0);
        wait_out(4);
        check_out("jal", make_out(reset_pc + 4, jal_word(21'h00040), fetch_pkg::cls_jal,
                  1'b0), got_q[1]);
        check_addr("jal forward", reset_pc + 32'h44, addr_q[2]);
        check_addr("jal backward", reset_pc + 32'h24, addr_q[3]);
        check_cycles("jal", out_cyc_q[1] + 2, first_rise_after(out_cyc_q[1]));
    endtask

    task automatic test_stalls();
        reset_dut("stall", $random(seed) & 3);
        imem_i.mem[0] = lw_word;
        imem_i.mem[1] = mul_word;
        wait_out(1);
        idle_cycles();
        // wrong completion while a load is pending.
        pulse_done(1'b0, 1'b1);
        idle_cycles();
        pulse_done(1'b1, 1'b0);
        wait_out(2);
        check_out("stall mem", make_out(reset_pc, lw_word, fetch_pkg::cls_mem, 1'b0), got_q[0]);
        check_out("stall md", make_out(reset_pc + 4, mul_word, fetch_pkg::cls_muldiv, 1'b0),
                  got_q[1]);
        check_addr("stall mem", reset_pc + 4, addr_q[1]);
        check_cycles("stall mem", pulse_cyc + 2, first_rise_after(out_cyc_q[0]));
        idle_cycles();
        pulse_done(1'b0, 1'b1);
        wait_out(3);
        check_addr("stall md", reset_pc + 8, addr_q[2]);
        check_cycles("stall md", pulse_cyc + 2, first_rise_after(out_cyc_q[1]));
    endtask

    task automatic test_redirect();
        reset_dut("redirect", $random(seed) & 3);
        imem_i.mem[0]  = jalr_word;
        imem_i.mem[64] = beq_word;
        while (!arvalid) begin
            step();
        end
        // sequencer is still fetching here.
        give_redirect(reset_pc + 32'h300);
        wait_out(1);
        idle_cycles();
        give_redirect(reset_pc + 32'h100);
        wait_out(2);
        check_out("redirect jalr", make_out(reset_pc, jalr_word, fetch_pkg::cls_ctrl, 1'b0),
                  got_q[0]);
        check_addr("redirect jalr", reset_pc + 32'h100, addr_q[1]);
        check_cycles("redirect jalr", pulse_cyc + 2, first_rise_after(out_cyc_q[0]));
        check_out("redirect branch", make_out(reset_pc + 32'h100, beq_word,
                  fetch_pkg::cls_ctrl, 1'b0), got_q[1]);
        idle_cycles();
        give_redirect(reset_pc + 32'h180);
        wait_out(3);
        check_addr("redirect branch", reset_pc + 32'h180, addr_q[2]);
    endtask

    task automatic test_backpressure();
        int span;
        reset_dut("backpressure", 4'd2 + ($random(seed) & 3));
        load_alu_block();
        while (got_q.size() < 8) begin
            out_ready = 1'b0;
            span      = $random(seed) & 3;
            repeat (span) step();
            out_ready = 1'b1;
            step();
        end
        check_alu_block("backpressure");
    endtask

    task automatic test_fault();
        reset_dut("fault", $random(seed) & 3);
        fault_addr = reset_pc + 8;
        wait_out(3);
        check_out("fault", make_out(reset_pc + 8, alu_word(2), fetch_pkg::cls_alu, 1'b1),
                  got_q[2]);
        idle_cycles();
        // completions do not release a halted fetch.
        pulse_done(1'b1, 1'b1);
        idle_cycles();
        give_redirect(reset_pc + 32'h40);
        wait_out(4);
        check_addr("fault resume", reset_pc + 32'h40, addr_q[3]);
        check_out("fault resume", make_out(reset_pc + 32'h40, alu_word(16),
                  fetch_pkg::cls_alu, 1'b0), got_q[3]);
        check_cycles("fault", pulse_cyc + 2, first_rise_after(out_cyc_q[2]));
    endtask

    initial begin
        seed       = 96407;
        cyc        = 0;
        checks     = 0;
        errors     = 0;
        pulse_cyc  = 0;
        cur_test   = "init";
        arvalid_q  = 1'b0;
        stalled_q  = 1'b0;
        r_wait     = 1'b0;
        rst_n      = 1'b0;
        out_ready  = 1'b0;
        mem_done   = 1'b0;
        md_done    = 1'b0;
        redirect   = '0;
        ar_delay   = '0;
        fault_addr = '1;
        test_sequential();
        test_jal();
        test_stalls();
        test_redirect();
        test_backpressure();
        test_fault();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- fetch_unit.f
hdl/fetch_pkg.sv
hdl/pc_sequencer.sv
hdl/axil_fetch_master.sv
hdl/inst_predecode.sv
hdl/fetch_unit.sv
test/imem_axil_model.sv
test/fetch_unit_tb.sv
